// ==== ifu_top.f ====
rtl/fetch_pkg.sv
rtl/imem_bus_if.sv
rtl/l1_icache.sv
rtl/ifu_ctrl.sv
rtl/ifu_top.sv
sim/tb_ifu_top.sv

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int idx_w  = 8;    // Default geometry, 256 lines.
  localparam int tag_w  = addr_w - idx_w - 2;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] inst_t;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [idx_w-1:0] index;
    logic [1:0]       offset;  // Byte offset, always zero for fetch.
  } fetch_fields_t;

  // One fetch word, read as a raw PC or split for the cache.
  typedef union packed {
    addr_t         raw;
    fetch_fields_t f;
  } fetch_addr_u;

  typedef enum logic [1:0] {
    idle     = 2'd0,
    lookup   = 2'd1,
    mem_wait = 2'd2,
    out_wait = 2'd3
  } ifu_state_e;

endpackage

`default_nettype wire

// ==== rtl/ifu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         fetch_valid_i,
  input  wire fetch_pkg::addr_t       fetch_pc_i,
  output logic                        fetch_ready_o,
  output logic                        inst_valid_o,
  output fetch_pkg::inst_t            inst_o,
  output fetch_pkg::addr_t            pc_o,
  input  wire                         inst_ready_i,
  input  wire                         flush_req_i,
  output fetch_pkg::fetch_addr_u      lookup_addr_o,
  input  wire                         hit_i,
  input  wire fetch_pkg::inst_t       hit_data_i,
  output logic                        fill_en_o,
  output fetch_pkg::inst_t            fill_data_o,
  output logic                        cache_flush_o,
  imem_bus_if.ctrl                    mem
);
  import fetch_pkg::*;

  ifu_state_e state_q;
  addr_t      pc_q;
  logic       ready_q;
  logic       valid_q;
  logic       req_q;
  logic       lk_armed_q;
  logic       hit_q;
  inst_t      hit_data_q;
  inst_t      inst_q;
  addr_t      pc_out_q;
  logic       flush_pend_q;
  logic       in_idle;
  logic       accept;
  logic       hit_done;

  assign in_idle  = (state_q == idle);
  assign accept   = in_idle && fetch_valid_i && ready_q;
  assign hit_done = (state_q == lookup) && lk_armed_q && hit_q;

  assign fetch_ready_o = ready_q;
  assign inst_valid_o  = valid_q;
  assign inst_o        = inst_q;
  assign pc_o          = pc_out_q;

  // Latched PC serves lookup, fill and the memory address.
  assign lookup_addr_o.raw = pc_q;
  assign mem.req           = req_q;
  assign mem.addr          = pc_q;

  assign fill_en_o     = (state_q == mem_wait) && req_q && mem.ack;  // First ack edge.
  assign fill_data_o   = mem.rdata;
  assign cache_flush_o = in_idle && (flush_pend_q || flush_req_i);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flush_pend_q <= 1'b0;
    end
    else if (in_idle)
    begin
      flush_pend_q <= 1'b0;
    end
    else if (flush_req_i)
    begin
      flush_pend_q <= 1'b1;  // Hold until back in idle.
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= idle;
      ready_q    <= 1'b0;
      valid_q    <= 1'b0;
      req_q      <= 1'b0;
      lk_armed_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        idle:
        begin
          if (accept)
          begin
            state_q    <= lookup;
            ready_q    <= 1'b0;
            lk_armed_q <= 1'b0;
          end
          else
          begin
            ready_q <= 1'b1;
          end
        end
        lookup:
        begin
          lk_armed_q <= 1'b1;  // Second cycle decides on the registered hit.
          if (lk_armed_q)
          begin
            if (hit_q)
            begin
              valid_q <= 1'b1;
              state_q <= out_wait;
            end
            else
            begin
              req_q   <= 1'b1;
              state_q <= mem_wait;
            end
          end
        end
        mem_wait:
        begin
          if (req_q && mem.ack)
          begin
            req_q <= 1'b0;
          end
          else if (!req_q && !mem.ack)
          begin
            valid_q <= 1'b1;  // Handshake closed.
            state_q <= out_wait;
          end
        end
        out_wait:
        begin
          if (inst_ready_i)
          begin
            valid_q <= 1'b0;
            ready_q <= 1'b1;
            state_q <= idle;
          end
        end
        default:
        begin
          state_q <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    hit_q      <= hit_i;
    hit_data_q <= hit_data_i;
    if (accept)
    begin
      pc_q <= fetch_pc_i;
    end
    if (hit_done)
    begin
      inst_q   <= hit_data_q;
      pc_out_q <= pc_q;
    end
    else if (fill_en_o)
    begin
      inst_q   <= mem.rdata;
      pc_out_q <= pc_q;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
  parameter int num_lines = 256
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         fetch_valid_i,
  input  wire  [31:0] fetch_pc_i,
  output logic        fetch_ready_o,
  output logic        inst_valid_o,
  output logic [31:0] inst_o,
  output logic [31:0] pc_o,
  input  wire         inst_ready_i,
  input  wire         flush_i,
  output logic        imem_req_o,
  output logic [31:0] imem_addr_o,
  input  wire  [31:0] imem_rdata_i,
  input  wire         imem_ack_i
);
  import fetch_pkg::*;

  fetch_addr_u lookup_addr;
  logic        hit;
  inst_t       hit_data;
  logic        fill_en;
  inst_t       fill_data;
  logic        cache_flush;

  imem_bus_if u_bus ();

  // Memory port out to the pins.
  assign imem_req_o  = u_bus.req;
  assign imem_addr_o = u_bus.addr;
  assign u_bus.rdata = imem_rdata_i;
  assign u_bus.ack   = imem_ack_i;

  ifu_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_ready_o (fetch_ready_o),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_ready_i  (inst_ready_i),
    .flush_req_i   (flush_i),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .fill_en_o     (fill_en),
    .fill_data_o   (fill_data),
    .cache_flush_o (cache_flush),
    .mem           (u_bus)
  );

  l1_icache #(
    .num_lines (num_lines)
  ) u_cache (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .fill_en_i     (fill_en),
    .fill_addr_i   (lookup_addr),  // Fill goes to the line just looked up.
    .fill_data_i   (fill_data),
    .flush_i       (cache_flush)
  );

endmodule

`default_nettype wire

// ==== rtl/imem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack read port to instruction memory.
interface imem_bus_if;
  import fetch_pkg::*;

  logic  req;
  addr_t addr;
  inst_t rdata;
  logic  ack;

  modport ctrl (
    output req,
    output addr,
    input  rdata,
    input  ack
  );

  modport mem (
    input  req,
    input  addr,
    output rdata,
    output ack
  );

endinterface

`default_nettype wire

// ==== rtl/l1_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_icache #(
  parameter int num_lines = 256
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire fetch_pkg::fetch_addr_u lookup_addr_i,
  output logic                        hit_o,
  output fetch_pkg::inst_t            hit_data_o,
  input  wire                         fill_en_i,
  input  wire fetch_pkg::fetch_addr_u fill_addr_i,
  input  wire fetch_pkg::inst_t       fill_data_i,
  input  wire                         flush_i
);
  import fetch_pkg::*;

  localparam int idx_w      = $clog2(num_lines);
  localparam int word_w     = addr_w - 2;
  localparam int line_tag_w = word_w - idx_w;

  logic [word_w-1:0]     lk_word;
  logic [word_w-1:0]     fill_word;
  logic [idx_w-1:0]      lk_idx;
  logic [idx_w-1:0]      fill_idx;
  logic [line_tag_w-1:0] lk_tag;
  logic [line_tag_w-1:0] fill_tag;

  inst_t                 data_q [num_lines];
  logic [line_tag_w-1:0] tag_q  [num_lines];
  logic [num_lines-1:0]  valid_q;

  // Word address rebuilt from the split view, so any line count picks its own split.
  assign lk_word   = {lookup_addr_i.f.tag, lookup_addr_i.f.index};
  assign fill_word = {fill_addr_i.f.tag, fill_addr_i.f.index};

  assign lk_idx   = lk_word[idx_w-1:0];
  assign lk_tag   = lk_word[word_w-1:idx_w];
  assign fill_idx = fill_word[idx_w-1:0];
  assign fill_tag = fill_word[word_w-1:idx_w];

  assign hit_o      = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign hit_data_o = data_q[lk_idx];

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;  // Invalidate every line.
    end
    else if (fill_en_i)
    begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      data_q[fill_idx] <= fill_data_i;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction-fetch testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --timescale 1ns/1ps \
  --top-module tb_ifu_top \
  -f ifu_top.f \
  -Mdir obj_dir \
  -o Vtb_ifu_top

# Result comes from the log rather than the exit status.
./obj_dir/Vtb_ifu_top > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Run failed, see sim.log."
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Run ended without a result, see sim.log."
  exit 1
fi
echo "Run passed."

// ==== sim/tb_ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_top;
  import fetch_pkg::*;

  localparam int    num_entries     = 14;
  localparam int    watchdog_cycles = num_entries * 40 + 16;
  localparam inst_t rdata_key       = 32'h13579bdf;

  typedef struct packed {
    addr_t      pc;
    logic       flush;
    logic [3:0] stall;    // Cycles with inst_ready_i held low.
    logic       exp_hit;
  } entry_t;

  logic  clk;
  logic  rst;
  logic  fetch_valid_i;
  addr_t fetch_pc_i;
  logic  fetch_ready_o;
  logic  inst_valid_o;
  inst_t inst_o;
  addr_t pc_o;
  logic  inst_ready_i;
  logic  flush_i;
  logic  imem_req_o;
  addr_t imem_addr_o;
  inst_t imem_rdata_i;
  logic  imem_ack_i;

  entry_t      stim [num_entries];
  int          read_count;
  addr_t       last_read_addr;
  logic [31:0] lfsr_q;

  ifu_top #(
    .num_lines (256)
  ) u_ifu_top (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_ready_o (fetch_ready_o),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_ready_i  (inst_ready_i),
    .flush_i       (flush_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .imem_ack_i    (imem_ack_i)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];  // Taps 32, 22, 2, 1.
    return {state[30:0], fb};
  endfunction

  task automatic draw_wait(output int cycles);
    logic [1:0] bits;
    bits = 2'b00;
    for (int i = 0; i < 2; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[0], lfsr_q[0]};
    end
    cycles = {30'b0, bits} + 1;
  endtask

  task automatic check_inst(input inst_t exp, input inst_t act, input string name);
    if (act !== exp)
    begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_pc(input addr_t exp, input addr_t act, input string name);
    if (act !== exp)
    begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_count(input int exp, input int act, input string name);
    if (act != exp)
    begin
      $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic check_flag(input logic exp, input logic act, input string name);
    if (act !== exp)
    begin
      $display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic set_entry(input int idx, input addr_t pc, input logic flush,
                           input logic [3:0] stall, input logic exp_hit);
    stim[idx].pc      = pc;
    stim[idx].flush   = flush;
    stim[idx].stall   = stall;
    stim[idx].exp_hit = exp_hit;
  endtask

  task automatic load_table();
    set_entry(0,  32'h0000_0100, 1'b0, 4'd0, 1'b0);
    set_entry(1,  32'h0000_0100, 1'b0, 4'd0, 1'b1);
    set_entry(2,  32'h0000_0104, 1'b0, 4'd2, 1'b0);
    set_entry(3,  32'h0000_0104, 1'b0, 4'd3, 1'b1);
    set_entry(4,  32'h0000_0500, 1'b0, 4'd0, 1'b0);  // Same index as 0x100.
    set_entry(5,  32'h0000_0100, 1'b0, 4'd1, 1'b0);
    set_entry(6,  32'h0000_0500, 1'b0, 4'd0, 1'b0);
    set_entry(7,  32'h0000_0100, 1'b0, 4'd0, 1'b0);
    set_entry(8,  32'h0000_0104, 1'b0, 4'd0, 1'b1);
    set_entry(9,  32'h0000_0104, 1'b1, 4'd0, 1'b0);  // Flush drops the line.
    set_entry(10, 32'h0000_0104, 1'b0, 4'd5, 1'b1);
    set_entry(11, 32'h0000_0100, 1'b0, 4'd0, 1'b0);
    set_entry(12, 32'h8000_0ffc, 1'b0, 4'd4, 1'b0);
    set_entry(13, 32'h8000_0ffc, 1'b0, 4'd1, 1'b1);
  endtask

  task automatic run_entry(input entry_t e, input addr_t next_pc);
    inst_t held_inst;
    addr_t held_pc;
    int    base_count;
    base_count = read_count;
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_pc_i    <= e.pc;
    flush_i       <= e.flush;
    @(negedge clk);
    while (fetch_ready_o !== 1'b1) @(negedge clk);
    @(posedge clk);
    fetch_valid_i <= 1'b0;  // Accepted on this edge.
    flush_i       <= 1'b0;
    @(negedge clk);
    while (inst_valid_o !== 1'b1) @(negedge clk);
    held_inst = inst_o;
    held_pc   = pc_o;
    repeat (e.stall)
    begin
      @(posedge clk);
      fetch_valid_i <= 1'b1;  // Next PC offered while the output is held.
      fetch_pc_i    <= next_pc;
      @(negedge clk);
      check_inst(held_inst, inst_o, "inst_o");
      check_pc(held_pc, pc_o, "pc_o");
      check_flag(1'b1, inst_valid_o, "inst_valid_o");
      check_flag(1'b0, fetch_ready_o, "fetch_ready_o");
    end
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    inst_ready_i  <= 1'b1;
    @(negedge clk);
    check_inst(e.pc ^ rdata_key, inst_o, "inst_o");
    check_pc(e.pc, pc_o, "pc_o");
    check_count(base_count + (e.exp_hit ? 0 : 1), read_count, "read_count");
    if (!e.exp_hit)
    begin
      check_pc(e.pc, last_read_addr, "imem_addr_o");
    end
    @(posedge clk);
    inst_ready_i <= 1'b0;  // Delivered on this edge.
  endtask

  // Four-phase memory model.
  always
  begin : mem_responder
    int delay;
    @(negedge clk);
    if (!rst && imem_req_o === 1'b1 && imem_ack_i === 1'b0)
    begin
      read_count     = read_count + 1;
      last_read_addr = imem_addr_o;
      draw_wait(delay);
      repeat (delay) @(posedge clk);
      imem_rdata_i <= imem_addr_o ^ rdata_key;
      imem_ack_i   <= 1'b1;
      @(negedge clk);
      while (imem_req_o === 1'b1) @(negedge clk);
      draw_wait(delay);
      repeat (delay) @(posedge clk);
      imem_ack_i <= 1'b0;
    end
  end

  initial
  begin
    #(watchdog_cycles * 20);
    $display("Watchdog expired after %0d cycles, the run timed out.", watchdog_cycles);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout.");
  end

  initial
  begin
    clk            = 1'b0;
    rst            = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_pc_i     = '0;
    inst_ready_i   = 1'b0;
    flush_i        = 1'b0;
    imem_rdata_i   = '0;
    imem_ack_i     = 1'b0;
    read_count     = 0;
    last_read_addr = '0;
    lfsr_q         = 32'h46b4;
    load_table();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag(1'b0, inst_valid_o, "inst_valid_o");
    check_flag(1'b0, imem_req_o, "imem_req_o");
    check_flag(1'b0, fetch_ready_o, "fetch_ready_o");
    for (int n = 0; n < num_entries; n++)
    begin
      run_entry(stim[n], stim[(n + 1) % num_entries].pc);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire
